//--- control_unit.f
+incdir+source
source/cu_pipe_pkg.sv
source/cu_debug_pkg.sv
source/cu_redirect_if.sv
source/cu_redirect_state.sv
source/cu_debug_fsm.sv
source/cu_fetch_steer.sv
source/cu_backend_ctrl.sv
source/control_unit.sv
test/control_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the control unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f control_unit.f --top-module control_unit_tb \
    -o control_unit_sim &&
./obj_dir/control_unit_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- test/control_unit_stimulus.txt
# columns: test id, input word, expected output word, check mask (hex)
# one line per clock cycle, bit layout as packed in control_unit_tb
1 000000000006 0000000007F0 0000000007FF
1 00000000000A 000000000070 0000000007FF
1 000000000003 000000000030 0000000007FF
1 000000000012 000000004381 00000000F7FF
1 000000000016 0000000047F0 00000000F7FF
1 00000000000B 000000000070 0000000007FF
1 000000000013 0000000043B0 00000000F7FF
2 132000001402 13020B117806 FFFFFFFFFFFF
2 051000001C02 000109200001 FFFFFFFFFFFF
2 1F3000000402 1F030B017806 FFFFFFFFFFFF
3 000000006002 000008000001 FFFFFFFFFFFF
3 000000000002 000009C0F80A FFFFFFFFFFFF
3 000000000002 000009000001 FFFFFFFFFFFF
3 000000006002 000008000001 FFFFFFFFFFFF
3 000000006002 000009C4F80A FFFFFFFFFFFF
3 000000006002 000008000001 FFFFFFFFFFFF
3 000000000002 000009C0F80A FFFFFFFFFFFF
3 000000000002 000009000001 FFFFFFFFFFFF
4 000001100002 000009000800 FFFFFFFFFFFF
4 000000000002 000009000800 FFFFFFFFFFFF
4 000000000002 000009000800 FFFFFFFFFFFF
4 000000042002 000009040810 FFFFFFFFFFFF
4 000000000002 00000900180E FFFFFFFFFFFF
4 000000000002 000009000001 FFFFFFFFFFFF
5 000080000002 000009000001 FFFFFFFFFFFF
5 000000000002 000009000010 FFFFFFFFFFFF
5 000020000002 000019000010 FFFFFFFFFFFF
5 000000000002 000005000010 FFFFFFFFFFFF
5 000100000002 000025000010 FFFFFFFFFFFF
5 000000000002 000009000001 FFFFFFFFFFFF
6 000000000302 000009080001 FFFFFFFFFFFF
6 000000000382 000009000081 FFFFFFFFFFFF
6 000000000312 000009004381 FFFFFFFFFFFF
6 000000000702 00000B017806 FFFFFFFFFFFF
6 000000000002 000009000001 FFFFFFFFFFFF

//--- test/control_unit_tb.sv
/*
 * Data-driven testbench for the control unit. Reads one line per cycle
 * from the stimulus file, drives the DUT inputs on the rising edge and
 * checks the masked outputs at the falling edge.
 */
`timescale 1ns/10ps
`include "cu_config.svh"

module control_unit_tb
    import cu_pipe_pkg::*;
;

    localparam int WORD_W      = 40 + `CU_GL_IDX_DATA_W;
    localparam int MAX_LINES   = 200;
    localparam int RESET_CYC   = 8;
    localparam int RUN_TIMEOUT = 20;

    logic clk_i;
    logic rstn_i;
    logic [63:0] in_word;
    logic [WORD_W-1:0] out_word;
    int n_checks;

    // DUT outputs
    next_pc_sel_t next_pc_sel;
    sel_addr_t    sel_addr_if;
    chkp_t        recover_chkp;
    gl_index_t    flush_gl_index;
    logic [30:4]  flags;

    control_unit dut0 (
        .clk_i, .rstn_i,
        .miss_icache_i        (in_word[0]),
        .ready_icache_i       (in_word[1]),
        .csr_stall_i          (in_word[2]),
        .ir_full_iq_i         (in_word[3]),
        .rr_gl_full_i         (in_word[4]),
        .exe_stall_i          (in_word[5]),
        .ir_empty_free_list_i (in_word[6]),
        .ir_out_of_chkp_i     (in_word[7]),
        .ir_valid_i           (in_word[8]),
        .ir_is_branch_i       (in_word[9]),
        .wb_valid_i           (in_word[10]),
        .wb_branch_ok_i       (in_word[11]),
        .wb_chkp_done_i       (in_word[12]),
        .commit_valid_i       (in_word[13]),
        .commit_xcpt_i        (in_word[14]),
        .commit_ecall_i       (in_word[15]),
        .commit_fence_i       (in_word[16]),
        .commit_fencei_i      (in_word[17]),
        .commit_csr_fence_i   (in_word[18]),
        .commit_stall_i       (in_word[19]),
        .id_valid_i           (in_word[20]),
        .id_is_branch_i       (in_word[21]),
        .id_pred_branch_i     (in_word[22]),
        .id_jal_i             (in_word[23]),
        .id_csr_fence_i       (in_word[24]),
        .csr_debug_step_i     (in_word[25]),
        .csr_eret_i           (in_word[26]),
        .csr_xcpt_i           (in_word[27]),
        .csr_debug_mode_i     (in_word[28]),
        .gl_empty_i           (in_word[29]),
        .halt_on_reset_i      (in_word[30]),
        .halt_req_i           (in_word[31]),
        .resume_req_i         (in_word[32]),
        .progbuf_req_i        (in_word[33]),
        .wb_chkp_i            (in_word[37:36]),
        .wb_gl_index_i        (in_word[44:40]),
        .next_pc_sel_o        (next_pc_sel),
        .sel_addr_if_o        (sel_addr_if),
        .stall_if1_o          (flags[4]),
        .stall_if2_o          (flags[5]),
        .stall_id_o           (flags[6]),
        .stall_iq_o           (flags[7]),
        .stall_ir_o           (flags[8]),
        .stall_rr_o           (flags[9]),
        .stall_exe_o          (flags[10]),
        .flush_if_o           (flags[11]),
        .flush_id_o           (flags[12]),
        .flush_ir_o           (flags[13]),
        .flush_rr_o           (flags[14]),
        .flush_exe_o          (flags[15]),
        .kill_exe_o           (flags[16]),
        .invalidate_icache_o  (flags[17]),
        .invalidate_buffer_o  (flags[18]),
        .do_checkpoint_o      (flags[19]),
        .do_recover_o         (flags[20]),
        .delete_chkp_o        (flags[21]),
        .recover_commit_o     (flags[22]),
        .flush_gl_commit_o    (flags[23]),
        .enable_commit_o      (flags[24]),
        .flush_gl_o           (flags[25]),
        .halted_o             (flags[26]),
        .running_o            (flags[27]),
        .halt_ack_o           (flags[28]),
        .resume_ack_o         (flags[29]),
        .progbuf_ack_o        (flags[30]),
        .recover_chkp_o       (recover_chkp),
        .flush_gl_index_o     (flush_gl_index)
    );

    // same bit layout as the expected column of the data file
    assign out_word = {3'b000, flush_gl_index, 6'b000000, recover_chkp, 1'b0, flags,
                       sel_addr_if, next_pc_sel};

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "stall_priority";
            2:       return "wb_mispredict";
            3:       return "commit_exception";
            4:       return "csr_fence";
            5:       return "debug_halt_resume";
            6:       return "rename_checkpoint";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [WORD_W-1:0] expected,
                           input logic [WORD_W-1:0] actual);
        n_checks = n_checks + 1;
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    initial begin
        int fd;
        int cnt;
        int id;
        int lines;
        int rst_cycles;
        int guard;
        logic [8*256-1:0] line;
        logic [63:0] stim;
        logic [63:0] expected;
        logic [63:0] mask;

        n_checks = 0;
        rstn_i  <= 1'b0;
        // icache ready and everything else idle
        in_word <= 64'h2;

        rst_cycles = 0;
        while (rst_cycles < RESET_CYC) begin
            @(posedge clk_i);
            rst_cycles = rst_cycles + 1;
        end
        rstn_i <= 1'b1;

        // the debug FSM passes its reset state before running_o rises
        guard = 0;
        while (flags[27] !== 1'b1) begin
            @(negedge clk_i);
            guard = guard + 1;
            if (guard > RUN_TIMEOUT) begin
                $display("DUT did not start running after reset was released");
                $display("TEST RESULT: FAIL");
                $fatal(1, "reset timeout");
            end
        end

        fd = $fopen("test/control_unit_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing stimulus");
        end

        lines = 0;
        while (!$feof(fd)) begin
            lines = lines + 1;
            if (lines > MAX_LINES) begin
                $display("stimulus file is longer than expected, giving up");
                $display("TEST RESULT: FAIL");
                $fatal(1, "read loop timeout");
            end
            line = '0;
            cnt = $fgets(line, fd);
            cnt = $sscanf(line, "%d %h %h %h", id, stim, expected, mask);
            // comment and blank lines do not parse
            if (cnt == 4) begin
                @(posedge clk_i);
                in_word <= stim;
                @(negedge clk_i);
                compare(test_name(id), expected[WORD_W-1:0] & mask[WORD_W-1:0],
                        out_word & mask[WORD_W-1:0]);
            end
        end
        $fclose(fd);

        if (n_checks == 0) begin
            $display("no checks were run");
            $display("TEST RESULT: FAIL");
            $fatal(1, "empty stimulus");
        end else begin
            $display("%0d cycles checked", n_checks);
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- source/control_unit.sv
/*
 * Control unit of the out-of-order core. Connects the redirect state,
 * the debug controller and the two steering blocks to the pipeline.
 */
`timescale 1ns/10ps

module control_unit
    import cu_pipe_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         miss_icache_i,
    input  logic         ready_icache_i,
    input  logic         id_valid_i,
    input  logic         id_is_branch_i,
    input  logic         id_pred_branch_i,
    input  logic         id_jal_i,
    input  logic         id_csr_fence_i,
    input  logic         ir_valid_i,
    input  logic         ir_is_branch_i,
    input  logic         ir_full_iq_i,
    input  logic         ir_empty_free_list_i,
    input  logic         ir_out_of_chkp_i,
    input  logic         rr_gl_full_i,
    input  logic         exe_stall_i,
    input  logic         wb_valid_i,
    input  logic         wb_branch_ok_i,
    input  logic         wb_chkp_done_i,
    input  chkp_t        wb_chkp_i,
    input  gl_index_t    wb_gl_index_i,
    input  logic         commit_valid_i,
    input  logic         commit_xcpt_i,
    input  logic         commit_ecall_i,
    input  logic         commit_fence_i,
    input  logic         commit_fencei_i,
    input  logic         commit_csr_fence_i,
    input  logic         commit_stall_i,
    input  logic         csr_stall_i,
    input  logic         csr_eret_i,
    input  logic         csr_xcpt_i,
    input  logic         csr_debug_mode_i,
    input  logic         csr_debug_step_i,
    input  logic         gl_empty_i,
    input  logic         halt_on_reset_i,
    input  logic         halt_req_i,
    input  logic         resume_req_i,
    input  logic         progbuf_req_i,
    output next_pc_sel_t next_pc_sel_o,
    output sel_addr_t    sel_addr_if_o,
    output logic         stall_if1_o,
    output logic         stall_if2_o,
    output logic         stall_id_o,
    output logic         stall_iq_o,
    output logic         stall_ir_o,
    output logic         stall_rr_o,
    output logic         stall_exe_o,
    output logic         flush_if_o,
    output logic         flush_id_o,
    output logic         flush_ir_o,
    output logic         flush_rr_o,
    output logic         flush_exe_o,
    output logic         kill_exe_o,
    output logic         invalidate_icache_o,
    output logic         invalidate_buffer_o,
    output logic         do_checkpoint_o,
    output logic         do_recover_o,
    output logic         delete_chkp_o,
    output chkp_t        recover_chkp_o,
    output logic         recover_commit_o,
    output logic         flush_gl_commit_o,
    output logic         enable_commit_o,
    output logic         flush_gl_o,
    output gl_index_t    flush_gl_index_o,
    output logic         halted_o,
    output logic         running_o,
    output logic         halt_ack_o,
    output logic         resume_ack_o,
    output logic         progbuf_ack_o
);

    logic on_halt;

    cu_redirect_if redir ();

    cu_redirect_state u_redirect_state (
        .clk_i, .rstn_i, .id_valid_i, .id_is_branch_i, .id_pred_branch_i, .id_jal_i,
        .id_csr_fence_i, .csr_debug_step_i, .wb_valid_i, .wb_branch_ok_i,
        .commit_valid_i, .commit_xcpt_i, .commit_ecall_i, .commit_csr_fence_i,
        .csr_eret_i, .csr_xcpt_i, .csr_debug_mode_i,
        .redir (redir.src)
    );

    cu_debug_fsm u_debug_fsm (
        .clk_i, .rstn_i, .halt_on_reset_i, .halt_req_i, .resume_req_i, .progbuf_req_i,
        .gl_empty_i, .csr_debug_mode_i,
        .on_halt_o (on_halt),
        .halted_o, .running_o, .halt_ack_o, .resume_ack_o, .progbuf_ack_o
    );

    // fetch keeps its PC whenever the back end stalls fetch 1
    cu_fetch_steer u_fetch_steer (
        .redir       (redir.sink),
        .on_halt_i   (on_halt),
        .stall_if1_i (stall_if1_o),
        .id_valid_i, .id_csr_fence_i, .commit_valid_i, .commit_fence_i,
        .commit_fencei_i, .commit_csr_fence_i, .csr_stall_i,
        .next_pc_sel_o, .sel_addr_if_o, .flush_if_o, .flush_id_o,
        .invalidate_icache_o, .invalidate_buffer_o
    );

    cu_backend_ctrl u_backend_ctrl (
        .redir     (redir.sink),
        .on_halt_i (on_halt),
        .miss_icache_i, .ready_icache_i, .csr_stall_i, .ir_valid_i, .ir_is_branch_i,
        .ir_full_iq_i, .ir_empty_free_list_i, .ir_out_of_chkp_i, .rr_gl_full_i,
        .exe_stall_i, .wb_chkp_done_i, .wb_chkp_i, .wb_gl_index_i, .commit_valid_i,
        .commit_csr_fence_i, .commit_stall_i,
        .stall_if1_o, .stall_if2_o, .stall_id_o, .stall_iq_o, .stall_ir_o, .stall_rr_o,
        .stall_exe_o, .flush_ir_o, .flush_rr_o, .flush_exe_o, .kill_exe_o,
        .do_checkpoint_o, .do_recover_o, .delete_chkp_o, .recover_chkp_o,
        .recover_commit_o, .flush_gl_commit_o, .enable_commit_o, .flush_gl_o,
        .flush_gl_index_o
    );

endmodule

//--- source/cu_backend_ctrl.sv
/*
 * Stall priority for the whole pipeline, back-end flushes, rename
 * checkpoint commands and commit control.
 */
`timescale 1ns/10ps

module cu_backend_ctrl
    import cu_pipe_pkg::*;
(
    cu_redirect_if.sink redir,
    input  logic        on_halt_i,
    input  logic        miss_icache_i,
    input  logic        ready_icache_i,
    input  logic        csr_stall_i,
    input  logic        ir_valid_i,
    input  logic        ir_is_branch_i,
    input  logic        ir_full_iq_i,
    input  logic        ir_empty_free_list_i,
    input  logic        ir_out_of_chkp_i,
    input  logic        rr_gl_full_i,
    input  logic        exe_stall_i,
    input  logic        wb_chkp_done_i,
    input  chkp_t       wb_chkp_i,
    input  gl_index_t   wb_gl_index_i,
    input  logic        commit_valid_i,
    input  logic        commit_csr_fence_i,
    input  logic        commit_stall_i,
    output logic        stall_if1_o,
    output logic        stall_if2_o,
    output logic        stall_id_o,
    output logic        stall_iq_o,
    output logic        stall_ir_o,
    output logic        stall_rr_o,
    output logic        stall_exe_o,
    output logic        flush_ir_o,
    output logic        flush_rr_o,
    output logic        flush_exe_o,
    output logic        kill_exe_o,
    output logic        do_checkpoint_o,
    output logic        do_recover_o,
    output logic        delete_chkp_o,
    output chkp_t       recover_chkp_o,
    output logic        recover_commit_o,
    output logic        flush_gl_commit_o,
    output logic        enable_commit_o,
    output logic        flush_gl_o,
    output gl_index_t   flush_gl_index_o
);

    // front end, highest priority first
    always_comb begin
        {stall_if1_o, stall_if2_o, stall_id_o} = 3'b000;
        if (csr_stall_i || ir_full_iq_i) begin
            {stall_if1_o, stall_if2_o, stall_id_o} = 3'b111;
        end else if (miss_icache_i) begin
            {stall_if1_o, stall_if2_o, stall_id_o} = 3'b110;
        end else if ((commit_valid_i && commit_csr_fence_i) || !ready_icache_i ||
                     on_halt_i) begin
            stall_if1_o = 1'b1;
        end
    end

    // back end, highest priority first
    always_comb begin
        {stall_iq_o, stall_ir_o, stall_rr_o, stall_exe_o} = 4'b0000;
        if (csr_stall_i) begin
            {stall_iq_o, stall_ir_o, stall_rr_o, stall_exe_o} = 4'b1111;
        end else if (exe_stall_i || rr_gl_full_i) begin
            {stall_iq_o, stall_ir_o, stall_rr_o, stall_exe_o} = 4'b1110;
        end else if (ir_empty_free_list_i || ir_out_of_chkp_i) begin
            stall_iq_o = 1'b1;
        end
    end

    // a mispredict lets the branch in execute retire its own result
    always_comb begin
        {flush_ir_o, flush_rr_o, flush_exe_o, kill_exe_o} = 4'b0000;
        if (redir.exception_q) begin
            {flush_ir_o, flush_rr_o, flush_exe_o} = 3'b111;
        end else if (redir.wb_mispredict) begin
            {flush_ir_o, flush_rr_o, kill_exe_o} = 3'b111;
        end else if (rr_gl_full_i) begin
            flush_rr_o = 1'b1;
        end
    end

    assign do_checkpoint_o = ir_valid_i & ir_is_branch_i & ~ir_out_of_chkp_i &
                             ~flush_ir_o & ~stall_ir_o;

    // chkp_done is only raised together with a valid write-back
    assign do_recover_o   = wb_chkp_done_i & redir.wb_mispredict;
    assign delete_chkp_o  = wb_chkp_done_i & ~redir.wb_mispredict;
    assign recover_chkp_o = wb_chkp_i;

    assign recover_commit_o  = redir.exception_q;
    assign flush_gl_commit_o = redir.exception_q;
    // hold commit while an exception is being raised
    assign enable_commit_o   = ~commit_stall_i & ~redir.xcpt_next;

    assign flush_gl_o       = redir.wb_mispredict;
    assign flush_gl_index_o = redir.wb_mispredict ? wb_gl_index_i : '0;

endmodule

//--- source/cu_fetch_steer.sv
/*
 * Front-end steering: next-PC and fetch-address selects, fetch and
 * decode flushes, and instruction cache and fetch buffer invalidation.
 */
`timescale 1ns/10ps

module cu_fetch_steer
    import cu_pipe_pkg::*;
(
    cu_redirect_if.sink  redir,
    input  logic         on_halt_i,
    input  logic         stall_if1_i,
    input  logic         id_valid_i,
    input  logic         id_csr_fence_i,
    input  logic         commit_valid_i,
    input  logic         commit_fence_i,
    input  logic         commit_fencei_i,
    input  logic         commit_csr_fence_i,
    input  logic         csr_stall_i,
    output next_pc_sel_t next_pc_sel_o,
    output sel_addr_t    sel_addr_if_o,
    output logic         flush_if_o,
    output logic         flush_id_o,
    output logic         invalidate_icache_o,
    output logic         invalidate_buffer_o
);

    logic redirect;
    logic fence_pending;

    assign redirect = redir.exception_q | redir.csr_q | redir.wb_mispredict;

    assign fence_pending = (id_valid_i & id_csr_fence_i) | redir.fence_in_pipe |
                           (commit_valid_i & commit_fence_i);

    always_comb begin
        if (redirect || redir.id_jump) begin
            next_pc_sel_o = NEXT_PC_SEL_JUMP;
        end else if (stall_if1_i || fence_pending || on_halt_i) begin
            next_pc_sel_o = NEXT_PC_SEL_KEEP_PC;
        end else begin
            next_pc_sel_o = NEXT_PC_SEL_BP_OR_PC_4;
        end
    end

    // trap vector and return address come from the CSR file
    always_comb begin
        if (redir.exception_q) begin
            sel_addr_if_o = SEL_JUMP_CSR;
        end else if (redir.csr_q) begin
            sel_addr_if_o = SEL_JUMP_CSR_RW;
        end else if (redir.wb_mispredict) begin
            sel_addr_if_o = SEL_JUMP_EXECUTION;
        end else begin
            sel_addr_if_o = SEL_JUMP_DECODE;
        end
    end

    // fetch alone is dropped when a fence or a decode jump redirects it
    always_comb begin
        flush_if_o = 1'b0;
        flush_id_o = 1'b0;
        if (redirect) begin
            flush_if_o = 1'b1;
            flush_id_o = 1'b1;
        end else if (!csr_stall_i) begin
            flush_if_o = id_csr_fence_i | redir.fence_in_pipe | commit_csr_fence_i |
                         redir.id_jump | (commit_valid_i & commit_fence_i);
        end
    end

    // fence.i may follow self-modifying code
    assign invalidate_icache_o = commit_valid_i & commit_fencei_i;
    assign invalidate_buffer_o = commit_valid_i &
                                 (commit_fencei_i | redir.exception_q |
                                  (commit_csr_fence_i & ~commit_fence_i));

endmodule

//--- source/cu_debug_fsm.sv
/*
 * Debug halt/resume controller. Reports the halted state to the
 * steering blocks and acknowledges debug module requests.
 */
`timescale 1ns/10ps

module cu_debug_fsm
    import cu_debug_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic halt_on_reset_i,
    input  logic halt_req_i,
    input  logic resume_req_i,
    input  logic progbuf_req_i,
    input  logic gl_empty_i,
    input  logic csr_debug_mode_i,
    output logic on_halt_o,
    output logic halted_o,
    output logic running_o,
    output logic halt_ack_o,
    output logic resume_ack_o,
    output logic progbuf_ack_o
);

    debug_state_t state_q;
    debug_state_t state_d;

    always_comb begin
        state_d       = state_q;
        on_halt_o     = 1'b0;
        halted_o      = 1'b0;
        running_o     = 1'b0;
        halt_ack_o    = 1'b0;
        resume_ack_o  = 1'b0;
        progbuf_ack_o = 1'b0;
        case (state_q)
            DEBUG_RESET: begin
                state_d    = halt_on_reset_i ? DEBUG_HALTED : DEBUG_RUNNING;
                halt_ack_o = halt_on_reset_i;
                on_halt_o  = halt_on_reset_i;
            end
            DEBUG_RUNNING: begin
                running_o = 1'b1;
                // entering debug mode from the core skips halting
                if (csr_debug_mode_i) begin
                    state_d    = DEBUG_HALTED;
                    halt_ack_o = 1'b1;
                end else if (halt_req_i) begin
                    state_d = DEBUG_HALTING;
                end
            end
            DEBUG_HALTING: begin
                running_o = 1'b1;
                on_halt_o = 1'b1;
                // wait for the graduation list to drain
                if (gl_empty_i || csr_debug_mode_i) begin
                    state_d    = DEBUG_HALTED;
                    halt_ack_o = 1'b1;
                end
            end
            DEBUG_HALTED: begin
                halted_o  = 1'b1;
                on_halt_o = 1'b1;
                if (resume_req_i) begin
                    state_d      = DEBUG_RUNNING;
                    resume_ack_o = 1'b1;
                end else if (progbuf_req_i) begin
                    state_d       = DEBUG_PROGBUF;
                    progbuf_ack_o = 1'b1;
                end
            end
            DEBUG_PROGBUF: begin
                // fetch runs the program buffer, so the core is not held
                halted_o = 1'b1;
                if (resume_req_i) begin
                    state_d      = DEBUG_RUNNING;
                    resume_ack_o = 1'b1;
                end else if (csr_debug_mode_i) begin
                    state_d    = DEBUG_HALTED;
                    halt_ack_o = 1'b1;
                end
            end
            default: begin
                state_d = DEBUG_RESET;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= DEBUG_RESET;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- source/cu_redirect_state.sv
/*
 * Decodes mispredict, jump and exception events once and keeps the
 * one-cycle exception and CSR redirect pulses and the fence flag.
 */
`timescale 1ns/10ps

module cu_redirect_state (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic id_valid_i,
    input  logic id_is_branch_i,
    input  logic id_pred_branch_i,
    input  logic id_jal_i,
    input  logic id_csr_fence_i,
    input  logic csr_debug_step_i,
    input  logic wb_valid_i,
    input  logic wb_branch_ok_i,
    input  logic commit_valid_i,
    input  logic commit_xcpt_i,
    input  logic commit_ecall_i,
    input  logic commit_csr_fence_i,
    input  logic csr_eret_i,
    input  logic csr_xcpt_i,
    input  logic csr_debug_mode_i,
    cu_redirect_if.src redir
);

    logic xcpt_event;
    logic csr_next;

    assign redir.wb_mispredict = wb_valid_i & ~wb_branch_ok_i;

    // valid jal, or something valid predicted taken that is not a branch
    assign redir.id_jump = id_valid_i & (id_jal_i | (~id_is_branch_i & id_pred_branch_i));

    assign xcpt_event = (commit_valid_i & (commit_xcpt_i | commit_ecall_i)) |
                        csr_eret_i | csr_xcpt_i | csr_debug_mode_i;

    // a pulse cannot fire two cycles in a row
    assign redir.xcpt_next = xcpt_event & ~redir.exception_q;
    assign csr_next = commit_valid_i & commit_csr_fence_i & ~xcpt_event & ~redir.csr_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            redir.exception_q <= 1'b0;
            redir.csr_q       <= 1'b0;
        end else begin
            redir.exception_q <= redir.xcpt_next;
            redir.csr_q       <= csr_next;
        end
    end

    // fence in flight, from decode until commit or a flush
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            redir.fence_in_pipe <= 1'b0;
        end else if (redir.exception_q | redir.wb_mispredict |
                     (commit_valid_i & commit_csr_fence_i)) begin
            redir.fence_in_pipe <= 1'b0;
        end else if (id_valid_i & (id_csr_fence_i | csr_debug_step_i)) begin
            redir.fence_in_pipe <= 1'b1;
        end
    end

endmodule

//--- source/cu_redirect_if.sv
/*
 * Decoded redirect events and redirect state, shared by the
 * steering blocks of the control unit.
 */
`timescale 1ns/10ps

interface cu_redirect_if;

    logic wb_mispredict;
    logic id_jump;
    // exception event of this cycle, already masked by the pulse
    logic xcpt_next;
    logic exception_q;
    logic csr_q;
    logic fence_in_pipe;

    modport src (
        output wb_mispredict,
        output id_jump,
        output xcpt_next,
        output exception_q,
        output csr_q,
        output fence_in_pipe
    );

    modport sink (
        input wb_mispredict,
        input id_jump,
        input xcpt_next,
        input exception_q,
        input csr_q,
        input fence_in_pipe
    );

endinterface

//--- source/cu_debug_pkg.sv
/*
 * State encoding of the debug halt/resume controller.
 */
package cu_debug_pkg;

    typedef enum logic [2:0] {
        DEBUG_RESET   = 3'b000,
        DEBUG_RUNNING = 3'b001,
        DEBUG_HALTING = 3'b010,
        DEBUG_HALTED  = 3'b011,
        DEBUG_PROGBUF = 3'b100
    } debug_state_t;

endpackage

//--- source/cu_pipe_pkg.sv
/*
 * Types for pipeline steering: next-PC and fetch-address selects,
 * checkpoint ids and graduation-list indexes.
 */
`include "cu_config.svh"

package cu_pipe_pkg;

    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP_PC    = 2'b00,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'b01,
        NEXT_PC_SEL_JUMP       = 2'b10
    } next_pc_sel_t;

    // source of the jump address used by fetch
    typedef enum logic [1:0] {
        SEL_JUMP_DECODE    = 2'b00,
        SEL_JUMP_EXECUTION = 2'b01,
        SEL_JUMP_CSR       = 2'b10,
        SEL_JUMP_CSR_RW    = 2'b11
    } sel_addr_t;

    typedef logic [`CU_CHKP_W-1:0]   chkp_t;
    typedef logic [`CU_GL_IDX_W-1:0] gl_index_t;

endpackage

//--- source/cu_config.svh
/*
 * Width settings for the control unit.
 * Included by the pipeline package and by the testbench.
 */
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// rename checkpoint id
`define CU_CHKP_W 2

// graduation list index
`define CU_GL_IDX_W 5

// index field in the testbench data file, padded to whole hex digits
`define CU_GL_IDX_DATA_W 8

`endif
